// ==== Bender.yml ====
package:
  name: plic

sources:
  - files:
      - hw/bus_pkg.sv
      - hw/irq_pkg.sv
      - hw/irq_gateway.sv
      - hw/irq_timer.sv
      - hw/claim_fsm.sv
      - hw/plic_regs.sv
      - hw/plic_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/plic_tb.sv

// ==== hw/bus_pkg.sv ====
// peripheral bus types and register map
package bus_pkg;

	typedef logic [23:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// register addresses
	localparam bus_addr_t ADDR_ENABLE = 24'h002000;
	localparam bus_addr_t ADDR_CLAIM  = 24'h200004;
	localparam bus_addr_t ADDR_TIMER  = 24'h004000;

	// request as driven by the core, rw high for a write
	typedef struct packed {
		logic      request;
		logic      rw;
		bus_addr_t address;
		bus_data_t wdata;
	} bus_req_t;

	// one decoded command per accepted request
	typedef enum logic [2:0] {
		OP_NONE,
		OP_ENABLE_WRITE,
		OP_ENABLE_READ,
		OP_CLAIM,
		OP_COMPLETE,
		OP_TIMER_WRITE,
		OP_TIMER_READ
	} bus_op_t;

	typedef struct packed {
		bus_op_t   op;
		bus_data_t wdata;
	} reg_cmd_t;

endpackage

// ==== hw/claim_fsm.sv ====
// claim and complete controller
`timescale 1ns/1ps

module claim_fsm (
	input  logic              i_clock,
	input  logic              i_reset,
	input  bus_pkg::reg_cmd_t i_cmd,
	input  irq_pkg::irq_vec_t i_pending,
	output irq_pkg::irq_id_t  o_grant_id,
	output irq_pkg::irq_vec_t o_clear,
	output logic              o_interrupt
);

	import bus_pkg::*;
	import irq_pkg::*;

	claim_state_t state;
	irq_id_t      claimed_id;
	irq_id_t      grant_id;
	irq_vec_t     grant_vec;
	logic         complete_hit;

	// lowest pending source wins, nothing granted while claimed
	always_comb begin
		grant_id  = '0;
		grant_vec = '0;
		if (state == ST_IDLE) begin
			for (int i = NUM_SOURCES - 1; i >= 0; i--) begin
				if (i_pending[i]) begin
					grant_id  = irq_id_t'(i + 1);
					grant_vec = irq_vec_t'(1) << i;
				end
			end
		end
	end

	assign complete_hit = (i_cmd.op == OP_COMPLETE)
		&& (i_cmd.wdata == bus_data_t'(claimed_id));

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state      <= ST_IDLE;
			claimed_id <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_cmd.op == OP_CLAIM && grant_id != '0) begin
						state      <= ST_CLAIMED;
						claimed_id <= grant_id;
					end
				end
				ST_CLAIMED: begin
					// wrong ids are ignored
					if (complete_hit) begin
						state      <= ST_IDLE;
						claimed_id <= '0;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// clear lands in the gateway at the ready edge
	assign o_clear     = (i_cmd.op == OP_CLAIM) ? grant_vec : '0;
	assign o_grant_id  = grant_id;
	assign o_interrupt = (|i_pending) && (state == ST_IDLE);

	a_claimed_id_valid: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(state == ST_CLAIMED) |-> (claimed_id != '0)
	) else $error("claimed state without a claimed id");

	a_clear_onehot: assert property (
		@(posedge i_clock) disable iff (i_reset)
		$onehot0(o_clear)
	) else $error("more than one pending bit cleared");

endmodule

// ==== hw/irq_gateway.sv ====
// interrupt edge gateway
`timescale 1ns/1ps

module irq_gateway (
	input  logic              i_clock,
	input  logic              i_reset,
	input  logic [2:0]        i_pins,
	input  logic              i_tick,
	input  irq_pkg::irq_vec_t i_enable,
	input  irq_pkg::irq_vec_t i_clear,
	output irq_pkg::irq_vec_t o_pending
);

	import irq_pkg::*;

	logic [2:0] pin_meta;
	logic [2:0] pin_sync;
	irq_vec_t   level;
	irq_vec_t   prev;
	irq_vec_t   rise;
	irq_vec_t   pending;

	// source 0 comes from the timer, already in this clock domain
	assign level = {pin_sync, i_tick};
	assign rise  = level & ~prev;

	// two flop synchronizer for the external pins
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pin_meta <= '0;
			pin_sync <= '0;
		end else begin
			pin_meta <= i_pins;
			pin_sync <= pin_meta;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			prev    <= '0;
			pending <= '0;
		end else begin
			prev <= level;
			// a new edge wins over a clear in the same cycle
			pending <= (pending & ~i_clear) | (rise & i_enable);
		end
	end

	assign o_pending = pending;

endmodule

// ==== hw/irq_pkg.sv ====
// interrupt source types
package irq_pkg;

	localparam int NUM_SOURCES = 4;

	// timer counter and compare width
	localparam int TIMER_WIDTH = 16;

	// bit n is source n
	typedef logic [NUM_SOURCES-1:0] irq_vec_t;

	// 0 is no interrupt, source n reports id n+1
	typedef logic [2:0] irq_id_t;

	typedef enum logic {
		ST_IDLE,
		ST_CLAIMED
	} claim_state_t;

endpackage

// ==== hw/irq_timer.sv ====
// periodic interrupt timer
`timescale 1ns/1ps

module irq_timer (
	input  logic                            i_clock,
	input  logic                            i_reset,
	input  bus_pkg::reg_cmd_t               i_cmd,
	output logic [irq_pkg::TIMER_WIDTH-1:0] o_compare,
	output logic                            o_tick
);

	import bus_pkg::*;
	import irq_pkg::*;

	logic [TIMER_WIDTH-1:0] compare;
	logic [TIMER_WIDTH-1:0] count;
	logic                   wrap;

	// zero compare keeps the counter parked
	assign wrap = (compare != '0) && (count == compare);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			compare <= '0;
			count   <= '0;
			o_tick  <= 1'b0;
		end else if (i_cmd.op == OP_TIMER_WRITE) begin
			// new period starts from zero
			compare <= i_cmd.wdata[TIMER_WIDTH-1:0];
			count   <= '0;
			o_tick  <= 1'b0;
		end else begin
			o_tick <= wrap;
			if (wrap) begin
				count <= '0;
			end else if (compare != '0) begin
				count <= count + 1'b1;
			end
		end
	end

	assign o_compare = compare;

	// a stopped timer raises no tick
	a_tick_needs_compare: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_tick |-> (compare != '0)
	) else $error("timer tick with zero compare value");

endmodule

// ==== hw/plic_regs.sv ====
// bus decode and register file
`timescale 1ns/1ps

module plic_regs (
	input  logic                            i_clock,
	input  logic                            i_reset,
	input  bus_pkg::bus_req_t               i_req,
	input  irq_pkg::irq_id_t                i_grant_id,
	input  logic [irq_pkg::TIMER_WIDTH-1:0] i_compare,
	output bus_pkg::reg_cmd_t               o_cmd,
	output irq_pkg::irq_vec_t               o_enable,
	output bus_pkg::bus_data_t              o_rdata,
	output logic                            o_ready
);

	import bus_pkg::*;
	import irq_pkg::*;

	logic      accept;
	bus_op_t   op;
	irq_vec_t  enable;
	bus_data_t rdata_next;

	// no new request during the ready cycle
	assign accept = i_req.request && !o_ready;

	always_comb begin
		op = OP_NONE;
		if (accept) begin
			case (i_req.address)
				ADDR_ENABLE: op = i_req.rw ? OP_ENABLE_WRITE : OP_ENABLE_READ;
				ADDR_CLAIM:  op = i_req.rw ? OP_COMPLETE : OP_CLAIM;
				ADDR_TIMER:  op = i_req.rw ? OP_TIMER_WRITE : OP_TIMER_READ;
				default:     op = OP_NONE;
			endcase
		end
	end

	// read data, zero for writes and unmapped addresses
	always_comb begin
		case (op)
			OP_ENABLE_READ: rdata_next = bus_data_t'({enable, 1'b0});
			OP_CLAIM:       rdata_next = bus_data_t'(i_grant_id);
			OP_TIMER_READ:  rdata_next = bus_data_t'(i_compare);
			default:        rdata_next = '0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			enable  <= '0;
			o_rdata <= '0;
			o_ready <= 1'b0;
		end else begin
			if (op == OP_ENABLE_WRITE) begin
				enable <= i_req.wdata[NUM_SOURCES:1];
			end
			o_rdata <= rdata_next;
			o_ready <= accept;
		end
	end

	assign o_cmd.op    = op;
	assign o_cmd.wdata = i_req.wdata;
	assign o_enable    = enable;

	a_ready_single: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_ready |=> !o_ready
	) else $error("ready held for two cycles");

endmodule

// ==== hw/plic_top.sv ====
// platform interrupt controller
`timescale 1ns/1ps

module plic_top (
	input  logic               i_clock,
	input  logic               i_reset,
	input  logic [2:0]         i_interrupt_pins,
	input  logic               i_request,
	input  logic               i_rw,
	input  bus_pkg::bus_addr_t i_address,
	input  bus_pkg::bus_data_t i_wdata,
	output bus_pkg::bus_data_t o_rdata,
	output logic               o_ready,
	output logic               o_interrupt
);

	import bus_pkg::*;
	import irq_pkg::*;

	bus_req_t               req;
	reg_cmd_t               cmd;
	irq_vec_t               enable;
	irq_vec_t               pending;
	irq_vec_t               clear;
	irq_id_t                grant_id;
	logic [TIMER_WIDTH-1:0] compare;
	logic                   tick;

	assign req = '{request: i_request, rw: i_rw, address: i_address, wdata: i_wdata};

	plic_regs u_regs (
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_req      (req),
		.i_grant_id (grant_id),
		.i_compare  (compare),
		.o_cmd      (cmd),
		.o_enable   (enable),
		.o_rdata    (o_rdata),
		.o_ready    (o_ready)
	);

	irq_timer u_timer (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_cmd     (cmd),
		.o_compare (compare),
		.o_tick    (tick)
	);

	irq_gateway u_gateway (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_pins    (i_interrupt_pins),
		.i_tick    (tick),
		.i_enable  (enable),
		.i_clear   (clear),
		.o_pending (pending)
	);

	claim_fsm u_claim (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_cmd       (cmd),
		.i_pending   (pending),
		.o_grant_id  (grant_id),
		.o_clear     (clear),
		.o_interrupt (o_interrupt)
	);

endmodule

// ==== sim.f ====
+incdir+tb
hw/bus_pkg.sv
hw/irq_pkg.sv
hw/irq_gateway.sv
hw/irq_timer.sv
hw/claim_fsm.sv
hw/plic_regs.sv
hw/plic_top.sv
tb/plic_tb.sv

// ==== tb/plic_tb_model.svh ====
// interrupt controller reference model
`ifndef PLIC_TB_MODEL_SVH
`define PLIC_TB_MODEL_SVH

// an edge only latches when its source is enabled
function automatic irq_pkg::irq_vec_t model_edge(
	input irq_pkg::irq_vec_t pending,
	input irq_pkg::irq_vec_t enable,
	input int                source
);
	irq_pkg::irq_vec_t result;
	result = pending;
	if (enable[source]) begin
		result[source] = 1'b1;
	end
	return result;
endfunction

// lowest numbered pending source, reported as source + 1
function automatic irq_pkg::irq_id_t model_pick(input irq_pkg::irq_vec_t pending);
	irq_pkg::irq_id_t id;
	id = '0;
	for (int s = 0; s < irq_pkg::NUM_SOURCES; s++) begin
		if (pending[s] && id == '0) begin
			id = irq_pkg::irq_id_t'(s + 1);
		end
	end
	return id;
endfunction

`endif

// ==== tb/plic_tb.sv ====
// interrupt controller testbench
`timescale 1ns/1ps

module plic_tb;

	import bus_pkg::*;
	import irq_pkg::*;

	`include "plic_tb_model.svh"

	localparam int TIMEOUT = 64;

	logic      clock;
	logic      reset;
	logic [2:0] pins;
	logic      request;
	logic      rw;
	bus_addr_t address;
	bus_data_t wdata;
	bus_data_t rdata;
	logic      ready;
	logic      interrupt;
	integer    seed;
	irq_vec_t  m_enable;
	irq_vec_t  m_pending;
	irq_id_t   m_claimed;

	plic_top dut (
		.i_clock          (clock),
		.i_reset          (reset),
		.i_interrupt_pins (pins),
		.i_request        (request),
		.i_rw             (rw),
		.i_address        (address),
		.i_wdata          (wdata),
		.o_rdata          (rdata),
		.o_ready          (ready),
		.o_interrupt      (interrupt)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_data(input string name, input bus_data_t expected,
			input bus_data_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_id(input string name, input irq_id_t expected, input irq_id_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR %s expected %0d actual %0d", name, expected, actual));
		end
	endtask

	task automatic check_level(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR %s expected %b actual %b", name, expected, actual));
		end
	endtask

	// one request, held until the single ready cycle
	task automatic bus_access(input logic write, input bus_addr_t addr, input bus_data_t data,
			output bus_data_t result);
		int waited;
		waited = 0;
		@(posedge clock);
		request <= 1'b1;
		rw      <= write;
		address <= addr;
		wdata   <= data;
		@(negedge clock);
		while (!ready) begin
			check_data("rdata outside ready", '0, rdata);
			waited++;
			if (waited > TIMEOUT) begin
				abort_run("timeout while waiting for o_ready");
			end
			@(negedge clock);
		end
		result = rdata;
		@(posedge clock);
		request <= 1'b0;
		@(negedge clock);
		if (ready) begin
			abort_run("o_ready stayed high for a second cycle");
		end
		check_data("rdata after ready", '0, rdata);
	endtask

	task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
		bus_data_t result;
		bus_access(1'b1, addr, data, result);
		check_data("write rdata", '0, result);
	endtask

	task automatic bus_read(input bus_addr_t addr, output bus_data_t result);
		bus_access(1'b0, addr, '0, result);
	endtask

	task automatic claim_source(input string name, input irq_id_t expected,
			output irq_id_t actual);
		bus_data_t result;
		bus_read(ADDR_CLAIM, result);
		actual = result[2:0];
		check_id(name, expected, actual);
		check_data(name, bus_data_t'(expected), result);
	endtask

	// long enough for the synchronizer and edge detect to settle
	task automatic pulse_pin(input int pin);
		@(posedge clock);
		pins <= 3'b001 << pin;
		repeat (4) @(posedge clock);
		pins <= 3'b000;
		repeat (4) @(posedge clock);
		m_pending = model_edge(m_pending, m_enable, pin + 1);
	endtask

	initial begin : stimulus
		bus_data_t  value;
		bus_data_t  written;
		bus_addr_t  addr;
		irq_id_t    id;
		irq_id_t    other;
		logic [15:0] period;
		int         waited;
		logic       drained;
		seed      = 32'h22886dec;
		reset     = 1'b1;
		pins      = '0;
		request   = 1'b0;
		rw        = 1'b0;
		address   = '0;
		wdata     = '0;
		m_enable  = '0;
		m_pending = '0;
		m_claimed = '0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_level("reset ready", 1'b0, ready);
		check_level("reset interrupt", 1'b0, interrupt);
		check_data("reset rdata", '0, rdata);

		// enable register readback
		repeat (8) begin
			written = $random(seed);
			bus_write(ADDR_ENABLE, written);
			bus_read(ADDR_ENABLE, value);
			check_data("enable readback", written & 32'h1e, value);
		end

		// random edges, claims in lowest-first order
		repeat (24) begin
			value = $random(seed);
			bus_write(ADDR_ENABLE, value);
			m_enable = value[4:1];
			repeat (1 + $unsigned($random(seed)) % 4) begin
				pulse_pin($unsigned($random(seed)) % 3);
			end
			@(negedge clock);
			check_level("interrupt after edges", |m_pending, interrupt);
			drained = 1'b0;
			while (!drained) begin
				claim_source("claim order", model_pick(m_pending), id);
				if (id == '0) begin
					drained = 1'b1;
				end else begin
					m_pending[id - 1] = 1'b0;
					m_claimed = id;
					check_level("interrupt while claimed", 1'b0, interrupt);
					claim_source("second claim", '0, other);
					if ($random(seed) & 1) begin
						other = (m_claimed % 7) + 1;
						bus_write(ADDR_CLAIM, bus_data_t'(other));
						check_level("wrong completion", 1'b0, interrupt);
						claim_source("claim after wrong completion", '0, other);
					end
					bus_write(ADDR_CLAIM, bus_data_t'(m_claimed));
					m_claimed = '0;
					check_level("interrupt after completion", |m_pending, interrupt);
				end
			end
		end

		// timer as source 0
		bus_write(ADDR_ENABLE, 32'h2);
		m_enable = 4'b0001;
		period = 2 + $unsigned($random(seed)) % 6;
		bus_write(ADDR_TIMER, bus_data_t'(period));
		bus_read(ADDR_TIMER, value);
		check_data("timer readback", bus_data_t'(period), value);
		waited = 0;
		while (!interrupt) begin
			waited++;
			if (waited > TIMEOUT) begin
				abort_run("timeout while waiting for the timer interrupt");
			end
			@(negedge clock);
		end
		claim_source("timer claim", 3'd1, id);
		bus_write(ADDR_CLAIM, 32'd1);
		bus_write(ADDR_TIMER, 32'd0);
		bus_read(ADDR_TIMER, value);
		check_data("timer stop readback", '0, value);
		// a tick may land before the stop
		bus_read(ADDR_CLAIM, value);
		if (value != '0) begin
			check_data("late timer claim", 32'd1, value);
			bus_write(ADDR_CLAIM, 32'd1);
		end
		repeat (4 * (period + 1)) @(posedge clock);
		@(negedge clock);
		check_level("timer stopped", 1'b0, interrupt);
		claim_source("claim after timer stop", '0, id);

		// unmapped addresses
		repeat (8) begin
			addr = $random(seed);
			if (addr == ADDR_ENABLE || addr == ADDR_CLAIM || addr == ADDR_TIMER) begin
				addr = 24'h000010;
			end
			bus_read(addr, value);
			check_data("unmapped read", '0, value);
			bus_write(addr, $random(seed));
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule
